//--- mem_types_pkg.sv
// Memory interface definitions
// Address, data and size types, the request struct and the helpers
// that align an access and mask data to its size
package mem_types_pkg;

  typedef logic [25:0] mem_addr_t;   // Byte address
  typedef logic [63:0] mem_data_t;   // Access data
  typedef logic [7:0]  lane_byte_t;  // One byte lane

  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_16 = 2'd1,
    SIZE_32 = 2'd2,
    SIZE_64 = 2'd3
  } mem_size_t;

  localparam int LANE_COUNT = 8;  // Byte lanes per 64-bit word

  typedef struct packed {
    logic      rd_enable;
    logic      wr_enable;
    mem_addr_t address;
    mem_size_t size;
    mem_data_t write_data;
  } mem_req_t;

  // Byte offset inside the word, aligned down to the size
  function automatic logic [2:0] size_offset(mem_addr_t address, mem_size_t size);
    case (size)
      SIZE_8:  return address[2:0];
      SIZE_16: return {address[2:1], 1'b0};
      SIZE_32: return {address[2], 2'b00};
      default: return 3'b000;
    endcase
  endfunction

  // Keeps the low bytes that an access of this size carries
  function automatic mem_data_t size_mask(mem_size_t size);
    case (size)
      SIZE_8:  return 64'h0000_0000_0000_00FF;
      SIZE_16: return 64'h0000_0000_0000_FFFF;
      SIZE_32: return 64'h0000_0000_FFFF_FFFF;
      default: return 64'hFFFF_FFFF_FFFF_FFFF;
    endcase
  endfunction

endpackage

//--- tester_pkg.sv
// Test sequencer definitions
// State encoding, counter width, pattern constants and status struct
package tester_pkg;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    WRITE_REQ,
    WRITE_WAIT,
    READ_REQ,
    READ_WAIT,
    HOLD,
    DONE
  } tester_state_t;

  typedef logic [15:0] count_t;  // Operation and error counts

  localparam mem_types_pkg::mem_data_t PATTERN_SEED = 64'h0000_0000_EFEF_CDF8;
  localparam mem_types_pkg::mem_addr_t ADDR_STRIDE  = 26'h9;  // Odd step, hits every offset

  typedef struct packed {
    logic   done;
    logic   result_valid;  // One cycle per finished operation
    logic   check_ok;
    count_t op_count;
    count_t error_count;
  } tester_status_t;

endpackage

//--- byte_lane_ram.sv
// Byte lane RAM
// One byte-wide synchronous memory with its own write enable
module byte_lane_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                           clock,
  input  logic                           write_enable,
  input  logic [$clog2(RAM_WORDS)-1:0]   word_index,
  input  mem_types_pkg::lane_byte_t      write_byte,
  output mem_types_pkg::lane_byte_t      read_byte
);
  import mem_types_pkg::*;

  lane_byte_t mem [RAM_WORDS];

  // Read returns the old byte when a write hits the same word
  always_ff @(posedge clock) begin
    if (write_enable) begin
      mem[word_index] <= write_byte;
    end
    read_byte <= mem[word_index];
  end

endmodule

//--- lane_steer.sv
// Lane steering
// Turns one request into per-lane write enables, the bytes for each
// lane and the word index shared by all lanes
module lane_steer #(
  parameter int RAM_WORDS = 256
) (
  input  mem_types_pkg::mem_req_t                                 req,
  input  logic                                                    accept,
  output logic [mem_types_pkg::LANE_COUNT-1:0]                    lane_write_enable,
  output mem_types_pkg::lane_byte_t [mem_types_pkg::LANE_COUNT-1:0] lane_bytes,
  output logic [$clog2(RAM_WORDS)-1:0]                            word_index
);
  import mem_types_pkg::*;

  localparam int INDEX_WIDTH = $clog2(RAM_WORDS);

  logic [2:0]            offset;
  logic [LANE_COUNT-1:0] base_mask;
  logic [LANE_COUNT-1:0] byte_mask;

  assign offset = size_offset(req.address, req.size);

  always_comb begin
    case (req.size)
      SIZE_8:  base_mask = 8'h01;
      SIZE_16: base_mask = 8'h03;
      SIZE_32: base_mask = 8'h0F;
      default: base_mask = 8'hFF;
    endcase
  end

  assign byte_mask = base_mask << offset;  // Offset is aligned, never spills over

  assign lane_write_enable = (accept && req.wr_enable) ? byte_mask : '0;

  // Low write bytes rotated up to start at the offset lane
  always_comb begin
    for (int lane = 0; lane < LANE_COUNT; lane++) begin
      lane_bytes[lane] = req.write_data[{3'(lane - int'(offset)), 3'b000} +: 8];
    end
  end

  // Bits above the offset pick the word, wrapping at RAM_WORDS
  assign word_index = req.address[3 +: INDEX_WIDTH];

endmodule

//--- read_align.sv
// Read alignment
// Shifts the lane outputs down by the byte offset, clears the bytes
// above the access size and holds the result
module read_align (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic                                                    capture,
  input  logic [2:0]                                              offset,
  input  mem_types_pkg::mem_size_t                                size,
  input  mem_types_pkg::lane_byte_t [mem_types_pkg::LANE_COUNT-1:0] lane_bytes,
  output mem_types_pkg::mem_data_t                                read_data
);
  import mem_types_pkg::*;

  mem_data_t lane_word;
  mem_data_t shifted;

  assign lane_word = mem_data_t'(lane_bytes);        // Lane 0 in the low byte
  assign shifted   = lane_word >> {offset, 3'b000};  // Offset in bytes

  // Holds until the next read completes
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_data <= '0;
    end else if (capture) begin
      read_data <= shifted & size_mask(size);
    end
  end

endmodule

//--- mem_controller.sv
// Memory controller
// Enable/busy access controller over eight byte-lane RAMs, with a
// fixed access delay and aligned, zero-filled read data
module mem_controller #(
  parameter int RAM_WORDS     = 256,
  parameter int ACCESS_CYCLES = 3
) (
  input  logic                     clock,
  input  logic                     reset,
  input  mem_types_pkg::mem_req_t  mem_req,
  output logic                     busy,
  output mem_types_pkg::mem_data_t read_data
);
  import mem_types_pkg::*;

  localparam int INDEX_WIDTH = $clog2(RAM_WORDS);
  localparam int COUNT_WIDTH = $clog2(ACCESS_CYCLES + 1);

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_BUSY,
    CTRL_COMPLETE
  } ctrl_state_t;

  ctrl_state_t                      state;
  logic [COUNT_WIDTH-1:0]           busy_count;
  logic                             accept;
  logic                             capture;

  // Request fields kept for the length of the access
  logic                             held_read;
  logic [2:0]                       held_offset;
  mem_size_t                        held_size;
  logic [INDEX_WIDTH-1:0]           held_index;

  logic [LANE_COUNT-1:0]            lane_write_enable;
  lane_byte_t [LANE_COUNT-1:0]      write_bytes;
  lane_byte_t [LANE_COUNT-1:0]      read_bytes;
  logic [INDEX_WIDTH-1:0]           steer_index;
  logic [INDEX_WIDTH-1:0]           ram_index;

  // Exactly one enable, and only while idle
  assign accept = (state == CTRL_IDLE) && (mem_req.rd_enable ^ mem_req.wr_enable);

  assign busy      = (state == CTRL_BUSY);
  assign capture   = busy && held_read && (busy_count == COUNT_WIDTH'(1));
  assign ram_index = busy ? held_index : steer_index;  // Requester may move its address

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= CTRL_IDLE;
      busy_count <= '0;
    end else begin
      case (state)
        CTRL_IDLE: begin
          if (accept) begin
            state      <= CTRL_BUSY;
            busy_count <= COUNT_WIDTH'(ACCESS_CYCLES);
          end
        end
        CTRL_BUSY: begin
          busy_count <= busy_count - 1'b1;
          if (busy_count == COUNT_WIDTH'(1)) begin
            state <= CTRL_COMPLETE;
          end
        end
        default: state <= CTRL_IDLE;  // Completion cycle ignores requests
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held_read   <= mem_req.rd_enable;
      held_offset <= size_offset(mem_req.address, mem_req.size);
      held_size   <= mem_req.size;
      held_index  <= steer_index;
    end
  end

  lane_steer #(
    .RAM_WORDS(RAM_WORDS)
  ) u_lane_steer (
    .req               (mem_req),
    .accept            (accept),
    .lane_write_enable (lane_write_enable),
    .lane_bytes        (write_bytes),
    .word_index        (steer_index)
  );

  for (genvar lane = 0; lane < LANE_COUNT; lane++) begin : g_lane
    byte_lane_ram #(
      .RAM_WORDS(RAM_WORDS)
    ) u_ram (
      .clock        (clock),
      .write_enable (lane_write_enable[lane]),
      .word_index   (ram_index),
      .write_byte   (write_bytes[lane]),
      .read_byte    (read_bytes[lane])
    );
  end

  read_align u_read_align (
    .clock      (clock),
    .reset      (reset),
    .capture    (capture),
    .offset     (held_offset),
    .size       (held_size),
    .lane_bytes (read_bytes),
    .read_data  (read_data)
  );

endmodule

//--- mem_tester.sv
// Memory test sequencer
// Runs TEST_COUNT write-then-read operations over all access sizes,
// checks each read and counts mismatches. Passes the host port
// through while no run is active
module mem_tester #(
  parameter int TEST_COUNT  = 16,
  parameter int HOLD_CYCLES = 2
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          start,
  input  mem_types_pkg::mem_req_t       host_req,
  input  logic                          busy,
  input  mem_types_pkg::mem_data_t      read_data,
  output mem_types_pkg::mem_req_t       mem_req,
  output tester_pkg::tester_status_t    status
);
  import mem_types_pkg::*;
  import tester_pkg::*;

  tester_state_t state;
  count_t        op_count;
  count_t        error_count;
  count_t        hold_count;
  logic          check_ok_q;

  // Pattern for the next operation
  mem_addr_t     pat_addr;
  mem_data_t     pat_data;

  // Current operation
  mem_addr_t     op_addr;
  mem_data_t     op_data;
  mem_size_t     op_size;

  logic          idle_like;
  logic          result_valid;
  logic          read_match;

  assign idle_like    = (state == IDLE) || (state == DONE);
  assign result_valid = (state == READ_WAIT) && !busy;  // Completion cycle of the read
  assign read_match   = (read_data == (op_data & size_mask(op_size)));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= IDLE;
      op_count    <= '0;
      error_count <= '0;
      hold_count  <= '0;
      check_ok_q  <= 1'b0;
      pat_addr    <= '0;
      pat_data    <= PATTERN_SEED;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (start) begin
            state       <= SETUP;
            op_count    <= '0;
            error_count <= '0;
            check_ok_q  <= 1'b0;
            pat_addr    <= '0;
            pat_data    <= PATTERN_SEED;
          end
        end
        SETUP: begin
          pat_addr <= pat_addr + ADDR_STRIDE;
          pat_data <= pat_data + 1'b1;
          state    <= WRITE_REQ;
        end
        WRITE_REQ: state <= WRITE_WAIT;
        WRITE_WAIT: begin
          if (!busy) begin
            state <= READ_REQ;
          end
        end
        READ_REQ: state <= READ_WAIT;
        READ_WAIT: begin
          if (!busy) begin
            check_ok_q <= read_match;
            op_count   <= op_count + 1'b1;
            hold_count <= count_t'(HOLD_CYCLES);
            state      <= HOLD;
            if (!read_match) begin
              error_count <= error_count + 1'b1;
            end
          end
        end
        HOLD: begin
          hold_count <= hold_count - 1'b1;
          if (hold_count <= count_t'(1)) begin
            state <= (op_count == count_t'(TEST_COUNT)) ? DONE : SETUP;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operation fields loaded once per operation
  always_ff @(posedge clock) begin
    if (state == SETUP) begin
      op_addr <= pat_addr;
      op_data <= pat_data;
      op_size <= mem_size_t'(op_count[1:0]);  // Cycles byte to doubleword
    end
  end

  always_comb begin
    if (idle_like) begin
      mem_req = host_req;
    end else begin
      mem_req.rd_enable  = (state == READ_REQ) || ((state == READ_WAIT) && busy);
      mem_req.wr_enable  = (state == WRITE_REQ) || ((state == WRITE_WAIT) && busy);
      mem_req.address    = op_addr;
      mem_req.size       = op_size;
      mem_req.write_data = op_data;
    end
  end

  always_comb begin
    status.done         = (state == DONE);
    status.result_valid = result_valid;
    status.check_ok     = result_valid ? read_match : check_ok_q;  // Valid with the pulse
    status.op_count     = op_count;
    status.error_count  = error_count;
  end

endmodule

//--- mem_test_top.sv
// Memory self-test top level
// Sequencer in front of the memory controller, host port shared
// with the sequencer while no run is active
module mem_test_top #(
  parameter int RAM_WORDS     = 256,
  parameter int ACCESS_CYCLES = 3,
  parameter int HOLD_CYCLES   = 2,
  parameter int TEST_COUNT    = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  mem_types_pkg::mem_req_t    host_req,
  output logic                       host_busy,
  output mem_types_pkg::mem_data_t   host_read_data,
  output tester_pkg::tester_status_t status
);
  import mem_types_pkg::*;

  mem_req_t mem_req;  // Sequencer or host request to the controller

  mem_tester #(
    .TEST_COUNT  (TEST_COUNT),
    .HOLD_CYCLES (HOLD_CYCLES)
  ) u_mem_tester (
    .clock     (clock),
    .reset     (reset),
    .start     (start),
    .host_req  (host_req),
    .busy      (host_busy),
    .read_data (host_read_data),
    .mem_req   (mem_req),
    .status    (status)
  );

  mem_controller #(
    .RAM_WORDS     (RAM_WORDS),
    .ACCESS_CYCLES (ACCESS_CYCLES)
  ) u_mem_controller (
    .clock     (clock),
    .reset     (reset),
    .mem_req   (mem_req),
    .busy      (host_busy),
    .read_data (host_read_data)
  );

endmodule

//--- tb_mem_test_top.sv
// Memory self-test testbench
// Host preload and access checks against a shadow memory, then two
// sequencer runs with pattern readback
module tb_mem_test_top;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_types_pkg::*;
  import tester_pkg::*;

  localparam int RAM_WORDS     = 256;
  localparam int ACCESS_CYCLES = 3;
  localparam int HOLD_CYCLES   = 2;
  localparam int TEST_COUNT    = 16;

  localparam int ROUNDS            = 8;  // Random accesses per size
  localparam int HOST_ACCESS_BOUND = ACCESS_CYCLES + 5;
  localparam int OP_BOUND          = 2 * (ACCESS_CYCLES + 2) + HOLD_CYCLES + 4;
  localparam int RUN_BOUND         = TEST_COUNT * OP_BOUND;
  localparam int START_AGAIN_CYCLE = 2 * OP_BOUND;  // Well inside a run
  localparam int HOST_ACCESSES     = RAM_WORDS + 12 * ROUNDS + 2 * TEST_COUNT;
  localparam int CYCLE_LIMIT       = 20 + HOST_ACCESSES * HOST_ACCESS_BOUND
                                     + 2 * (RUN_BOUND + 8);

  logic           clock;
  logic           reset;
  logic           start;
  mem_req_t       host_req;
  logic           host_busy;
  mem_data_t      host_read_data;
  tester_status_t status;

  lane_byte_t shadow [RAM_WORDS][LANE_COUNT];  // Expected memory contents
  logic [31:0] lcg_state;
  int checks;
  int errors;

  mem_test_top #(
    .RAM_WORDS     (RAM_WORDS),
    .ACCESS_CYCLES (ACCESS_CYCLES),
    .HOLD_CYCLES   (HOLD_CYCLES),
    .TEST_COUNT    (TEST_COUNT)
  ) dut0 (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .host_req       (host_req),
    .host_busy      (host_busy),
    .host_read_data (host_read_data),
    .status         (status)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mem_data_t fill_pattern(int word);
    return {32'(word) * 32'h9E37_79B9, 32'hA5C3_0000 | 32'(word)};
  endfunction

  // Shadow model of alignment, byte lanes and zero fill
  function automatic int access_bytes(mem_size_t size);
    return 1 << int'(size);
  endfunction

  function automatic int word_of(mem_addr_t address);
    return int'(address >> 3) % RAM_WORDS;
  endfunction

  function automatic int lane_of(mem_addr_t address, mem_size_t size);
    return int'(address[2:0]) & ~(access_bytes(size) - 1);  // Aligned down
  endfunction

  function automatic void shadow_write(mem_addr_t address, mem_size_t size, mem_data_t data);
    for (int k = 0; k < access_bytes(size); k++) begin
      shadow[word_of(address)][lane_of(address, size) + k] = data[8*k +: 8];
    end
  endfunction

  function automatic mem_data_t shadow_read(mem_addr_t address, mem_size_t size);
    mem_data_t result;
    result = '0;
    for (int k = 0; k < access_bytes(size); k++) begin
      result[8*k +: 8] = shadow[word_of(address)][lane_of(address, size) + k];
    end
    return result;
  endfunction

  task automatic check_value(input mem_data_t got, input mem_data_t expected,
                             input string what);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic check_flag(input logic condition, input string what);
    checks++;
    assert (condition === 1'b1) else begin
      errors++;
      $display("ERR %0t: %s", $time, what);
    end
  endtask

  // One enable/busy handshake, read data taken in the completion cycle
  task automatic host_access(input logic is_write, input mem_addr_t address,
                             input mem_size_t size, input mem_data_t write_data,
                             output mem_data_t read_data);
    mem_req_t req;
    req            = '0;
    req.rd_enable  = !is_write;
    req.wr_enable  = is_write;
    req.address    = address;
    req.size       = size;
    req.write_data = write_data;
    @(posedge clock);
    host_req <= req;
    @(negedge clock);
    while (!host_busy) @(negedge clock);
    while (host_busy) @(negedge clock);
    read_data = host_read_data;
    @(posedge clock);
    host_req <= '0;  // Dropped before the controller is idle again
  endtask

  task automatic host_write(input mem_addr_t address, input mem_size_t size,
                            input mem_data_t data);
    mem_data_t unused;
    host_access(1'b1, address, size, data, unused);
    shadow_write(address, size, data);
  endtask

  task automatic host_read(input mem_addr_t address, input mem_size_t size,
                           output mem_data_t data);
    host_access(1'b0, address, size, '0, data);
  endtask

  task automatic check_reset_state();
    @(negedge clock);
    check_flag(!status.done, "done high after reset");
    check_flag(!status.result_valid, "result_valid high after reset");
    check_flag(!status.check_ok, "check_ok high after reset");
    check_value(64'(status.op_count), '0, "op_count after reset");
    check_value(64'(status.error_count), '0, "error_count after reset");
    check_flag(!host_busy, "host_busy high after reset");
  endtask

  task automatic preload_memory();
    for (int w = 0; w < RAM_WORDS; w++) begin
      host_write(mem_addr_t'(w * 8), SIZE_64, fill_pattern(w));
    end
  endtask

  // Sized writes at random addresses, each checked with a full word read
  task automatic test_host_writes();
    mem_addr_t address;
    mem_data_t data;
    mem_data_t got;
    for (int r = 0; r < ROUNDS; r++) begin
      for (int s = 0; s < 4; s++) begin
        address = mem_addr_t'(lcg_next());
        data    = {lcg_next(), lcg_next()};
        host_write(address, mem_size_t'(s), data);
        host_read(address, SIZE_64, got);
        check_value(got, shadow_read(address, SIZE_64),
                    $sformatf("word after size %0d write at %h", s, address));
      end
    end
  endtask

  task automatic test_host_reads();
    mem_addr_t address;
    mem_data_t got;
    for (int r = 0; r < ROUNDS; r++) begin
      for (int s = 0; s < 4; s++) begin
        address = mem_addr_t'(lcg_next());
        host_read(address, mem_size_t'(s), got);
        check_value(got, shadow_read(address, mem_size_t'(s)),
                    $sformatf("size %0d read at %h", s, address));
      end
    end
  endtask

  task automatic run_sequencer(input string label);
    int cycles;
    int pulses;
    cycles = 0;
    pulses = 0;
    @(posedge clock);
    start <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
    @(negedge clock);
    check_flag(!status.done, {label, ": done still high after start"});
    check_value(64'(status.op_count), '0, {label, ": op_count after start"});
    check_value(64'(status.error_count), '0, {label, ": error_count after start"});
    while (!status.done && cycles < RUN_BOUND) begin
      @(posedge clock);
      start <= (cycles == START_AGAIN_CYCLE);  // Must be ignored mid-run
      @(negedge clock);
      cycles++;
      if (status.result_valid) begin
        pulses++;
        check_flag(status.check_ok, $sformatf("%s: check_ok low on op %0d", label, pulses));
      end
    end
    if (!status.done) begin
      errors++;
      $display("%s: sequencer did not finish within %0d cycles", label, RUN_BOUND);
    end else begin
      check_value(64'(pulses), 64'(TEST_COUNT), {label, ": result_valid pulses"});
      check_value(64'(status.op_count), 64'(TEST_COUNT), {label, ": op_count at done"});
      check_value(64'(status.error_count), '0, {label, ": error_count at done"});
    end
  endtask

  // Later operations overwrite bytes of earlier ones
  task automatic apply_sequencer_pattern();
    for (int i = 0; i < TEST_COUNT; i++) begin
      shadow_write(mem_addr_t'(i) * ADDR_STRIDE, mem_size_t'(i % 4),
                   PATTERN_SEED + mem_data_t'(i));
    end
  endtask

  task automatic test_pattern_readback();
    mem_addr_t address;
    mem_data_t got;
    for (int i = 0; i < TEST_COUNT; i++) begin
      address = mem_addr_t'(i) * ADDR_STRIDE;
      host_read(address, SIZE_64, got);
      check_value(got, shadow_read(address, SIZE_64),
                  $sformatf("pattern word of op %0d at %h", i, address));
    end
  endtask

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    start     = 1'b0;
    host_req  = '0;
    lcg_state = 32'h24a4_bd3b;
    checks    = 0;
    errors    = 0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    check_reset_state();
    preload_memory();
    test_host_writes();
    test_host_reads();
    run_sequencer("first run");
    apply_sequencer_pattern();
    test_pattern_readback();
    run_sequencer("second run");
    test_pattern_readback();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
mem_types_pkg.sv
tester_pkg.sv
byte_lane_ram.sv
lane_steer.sv
read_align.sv
mem_controller.sv
mem_tester.sv
mem_test_top.sv
tb_mem_test_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_mem_test_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
